// File: verilog/fb_pkg.sv
// Framebuffer control package
`default_nettype none

package fb_pkg;

    // Word and field widths
    localparam int CMD_WIDTH        = 32;
    localparam int OPCODE_WIDTH     = 4;
    localparam int SCREEN_POS_WIDTH = 11;
    localparam int FB_ADDR_WIDTH    = 20;
    localparam int PIXEL_WIDTH      = 16;

    typedef logic [CMD_WIDTH - 1 : 0]        cmd_word_t;
    typedef logic [SCREEN_POS_WIDTH - 1 : 0] screen_pos_t;
    typedef logic [FB_ADDR_WIDTH - 1 : 0]    fb_addr_t;

    // One RGB565 pixel or one depth value
    typedef logic [PIXEL_WIDTH - 1 : 0]      fb_pixel_t;

    // Opcode sits in the top nibble of every command word
    typedef enum logic [OPCODE_WIDTH - 1 : 0] {
        op_nop                = 4'd0,
        op_set_resolution     = 4'd1,
        op_set_scissor_start  = 4'd2,
        op_set_scissor_end    = 4'd3,
        op_set_scissor_enable = 4'd4,
        op_set_color_addr     = 4'd5,
        op_set_depth_addr     = 4'd6,
        op_set_clear_color    = 4'd7,
        op_set_clear_depth    = 4'd8,
        op_set_mask           = 4'd9,
        op_memset             = 4'd10,
        op_swap               = 4'd11
    } fb_opcode_e;

    // Target buffer of a memory write
    typedef enum logic {
        buf_color = 1'b0,
        buf_depth = 1'b1
    } fb_buf_e;

    // Clear engine walks color first, then depth
    typedef enum logic [1 : 0] {
        clr_idle  = 2'd0,
        clr_color = 2'd1,
        clr_depth = 2'd2
    } clear_state_e;

    // Swap handshake with the display side
    typedef enum logic [1 : 0] {
        sw_idle  = 2'd0,
        sw_pulse = 2'd1,
        sw_wait  = 2'd2
    } swap_state_e;

endpackage

`default_nettype wire

// File: verilog/fb_cmd_decode.sv
// Command decode and configuration registers
`timescale 1ns/1ps
`default_nettype none

module fb_cmd_decode (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  cmd_valid,
    input  fb_pkg::cmd_word_t    cmd_data,
    output logic                 cmd_ready,

    input  wire                  clear_busy,
    input  wire                  swap_busy,
    output logic                 clear_start,
    output logic                 clear_color_en,
    output logic                 clear_depth_en,
    output logic                 swap_start,

    output fb_pkg::screen_pos_t  x_res,
    output fb_pkg::screen_pos_t  y_res,
    output fb_pkg::screen_pos_t  sc_start_x,
    output fb_pkg::screen_pos_t  sc_start_y,
    output fb_pkg::screen_pos_t  sc_end_x,
    output fb_pkg::screen_pos_t  sc_end_y,
    output logic                 sc_enable,
    output fb_pkg::fb_addr_t     color_base,
    output fb_pkg::fb_addr_t     depth_base,
    output fb_pkg::fb_pixel_t    clear_rgb565,
    output fb_pkg::fb_pixel_t    clear_depth
);
    import fb_pkg::*;

    fb_opcode_e opcode;
    logic       accept;
    logic       pending;
    logic       mask_color;
    logic       mask_depth;

    assign opcode    = fb_opcode_e'(cmd_data[CMD_WIDTH - 1 -: OPCODE_WIDTH]);
    assign cmd_ready = !pending;
    assign accept    = cmd_valid && cmd_ready;

    // Start pulses fire on the accepting cycle so the stages react on the next one
    assign clear_start    = accept && (opcode == op_memset);
    assign clear_color_en = cmd_data[0] && mask_color;
    assign clear_depth_en = cmd_data[1] && mask_depth;
    assign swap_start     = accept && (opcode == op_swap);

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            pending      <= 1'b0;
            x_res        <= '0;
            y_res        <= '0;
            sc_start_x   <= '0;
            sc_start_y   <= '0;
            sc_end_x     <= '0;
            sc_end_y     <= '0;
            sc_enable    <= 1'b0;
            color_base   <= '0;
            depth_base   <= '0;
            clear_rgb565 <= '0;
            clear_depth  <= '0;
            mask_color   <= 1'b1;
            mask_depth   <= 1'b1;
        end
        else
        begin
            // Busy flags are already up on the cycle after a start
            if (pending && !clear_busy && !swap_busy)
            begin
                pending <= 1'b0;
            end

            if (accept)
            begin
                case (opcode)
                    op_set_resolution:
                    begin
                        x_res <= cmd_data[10 : 0];
                        y_res <= cmd_data[21 : 11];
                    end
                    op_set_scissor_start:
                    begin
                        sc_start_x <= cmd_data[10 : 0];
                        sc_start_y <= cmd_data[21 : 11];
                    end
                    op_set_scissor_end:
                    begin
                        sc_end_x <= cmd_data[10 : 0];
                        sc_end_y <= cmd_data[21 : 11];
                    end
                    op_set_scissor_enable: sc_enable  <= cmd_data[0];
                    op_set_color_addr:     color_base <= cmd_data[FB_ADDR_WIDTH - 1 : 0];
                    op_set_depth_addr:     depth_base <= cmd_data[FB_ADDR_WIDTH - 1 : 0];
                    // RGB888 down to RGB565, top bits of each channel
                    op_set_clear_color:
                        clear_rgb565 <= {cmd_data[23 : 19], cmd_data[15 : 10], cmd_data[7 : 3]};
                    op_set_clear_depth:    clear_depth <= cmd_data[PIXEL_WIDTH - 1 : 0];
                    op_set_mask:
                    begin
                        mask_color <= cmd_data[0];
                        mask_depth <= cmd_data[1];
                    end
                    op_memset, op_swap:    pending <= 1'b1;
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/fb_clear_engine.sv
// Scissored framebuffer clear engine
`timescale 1ns/1ps
`default_nettype none

module fb_clear_engine (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  clear_start,
    input  wire                  clear_color_en,
    input  wire                  clear_depth_en,
    output logic                 clear_busy,

    input  fb_pkg::screen_pos_t  x_res,
    input  fb_pkg::screen_pos_t  y_res,
    input  fb_pkg::screen_pos_t  sc_start_x,
    input  fb_pkg::screen_pos_t  sc_start_y,
    input  fb_pkg::screen_pos_t  sc_end_x,
    input  fb_pkg::screen_pos_t  sc_end_y,
    input  wire                  sc_enable,
    input  fb_pkg::fb_addr_t     color_base,
    input  fb_pkg::fb_addr_t     depth_base,
    input  fb_pkg::fb_pixel_t    clear_rgb565,
    input  fb_pkg::fb_pixel_t    clear_depth,

    output logic                 beat_valid,
    input  wire                  beat_ready,
    output fb_pkg::fb_addr_t     beat_addr,
    output fb_pkg::fb_pixel_t    beat_data,
    output fb_pkg::fb_buf_e      beat_buf
);
    import fb_pkg::*;

    clear_state_e state;
    screen_pos_t  x;
    screen_pos_t  y;
    fb_addr_t     row_base;
    fb_addr_t     x_ext;
    fb_addr_t     x_res_ext;
    logic         depth_pend;
    logic         active;
    logic         in_scissor;
    logic         last_x;
    logic         last_y;
    logic         advance;

    assign x_ext     = {{(FB_ADDR_WIDTH - SCREEN_POS_WIDTH){1'b0}}, x};
    assign x_res_ext = {{(FB_ADDR_WIDTH - SCREEN_POS_WIDTH){1'b0}}, x_res};

    assign active = (state == clr_color) || (state == clr_depth);
    assign last_x = (x == x_res - 11'd1);
    assign last_y = (y == y_res - 11'd1);

    // Pixels outside the scissor are stepped over without a beat
    assign in_scissor = !sc_enable
        || ((x >= sc_start_x) && (x < sc_end_x) && (y >= sc_start_y) && (y < sc_end_y));

    assign advance = active && (!in_scissor || beat_ready);

    assign beat_valid = active && in_scissor;
    assign beat_addr  = row_base + x_ext;
    assign beat_data  = (state == clr_depth) ? clear_depth : clear_rgb565;
    assign beat_buf   = (state == clr_depth) ? buf_depth : buf_color;

    // Stay busy while the output register still holds a stalled beat
    assign clear_busy = active || !beat_ready;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state      <= clr_idle;
            x          <= '0;
            y          <= '0;
            row_base   <= '0;
            depth_pend <= 1'b0;
        end
        else
        begin
            case (state)
                clr_idle:
                begin
                    if (clear_start && (x_res != '0) && (y_res != '0))
                    begin
                        x          <= '0;
                        y          <= '0;
                        depth_pend <= clear_depth_en;
                        if (clear_color_en)
                        begin
                            state    <= clr_color;
                            row_base <= color_base;
                        end
                        else if (clear_depth_en)
                        begin
                            state    <= clr_depth;
                            row_base <= depth_base;
                        end
                    end
                end
                clr_color, clr_depth:
                begin
                    if (advance)
                    begin
                        if (!last_x)
                        begin
                            x <= x + 11'd1;
                        end
                        else if (!last_y)
                        begin
                            // Next row starts one line further on
                            x        <= '0;
                            y        <= y + 11'd1;
                            row_base <= row_base + x_res_ext;
                        end
                        else
                        begin
                            x          <= '0;
                            y          <= '0;
                            depth_pend <= 1'b0;
                            if ((state == clr_color) && depth_pend)
                            begin
                                state    <= clr_depth;
                                row_base <= depth_base;
                            end
                            else
                            begin
                                state <= clr_idle;
                            end
                        end
                    end
                end
                default: state <= clr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/fb_output_stage.sv
// Write output register and swap handshake
`timescale 1ns/1ps
`default_nettype none

module fb_output_stage (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  beat_valid,
    output logic                 beat_ready,
    input  fb_pkg::fb_addr_t     beat_addr,
    input  fb_pkg::fb_pixel_t    beat_data,
    input  fb_pkg::fb_buf_e      beat_buf,

    output logic                 mem_wvalid,
    input  wire                  mem_wready,
    output fb_pkg::fb_addr_t     mem_waddr,
    output fb_pkg::fb_pixel_t    mem_wdata,
    output fb_pkg::fb_buf_e      mem_wbuf,

    input  wire                  swap_start,
    input  wire                  fb_swapped,
    output logic                 swap_fb,
    output logic                 swap_busy
);
    import fb_pkg::*;

    swap_state_e swap_state;

    // Take a new beat when empty or when the held one leaves this cycle
    assign beat_ready = !mem_wvalid || mem_wready;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            mem_wvalid <= 1'b0;
        end
        else if (beat_ready)
        begin
            mem_wvalid <= beat_valid;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beat_valid && beat_ready)
        begin
            mem_waddr <= beat_addr;
            mem_wdata <= beat_data;
            mem_wbuf  <= beat_buf;
        end
    end

    assign swap_fb   = (swap_state == sw_pulse);
    assign swap_busy = (swap_state != sw_idle);

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            swap_state <= sw_idle;
        end
        else
        begin
            case (swap_state)
                sw_idle:
                begin
                    if (swap_start)
                    begin
                        swap_state <= sw_pulse;
                    end
                end
                sw_pulse: swap_state <= sw_wait;
                sw_wait:
                begin
                    // Display side reports the new buffer as live
                    if (fb_swapped)
                    begin
                        swap_state <= sw_idle;
                    end
                end
                default: swap_state <= sw_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/rasterix_fb.sv
// Framebuffer control top level
`timescale 1ns/1ps
`default_nettype none

module rasterix_fb (
    input  wire                  aclk,
    input  wire                  rst_n,

    input  wire                  cmd_valid,
    output logic                 cmd_ready,
    input  fb_pkg::cmd_word_t    cmd_data,

    output logic                 mem_wvalid,
    input  wire                  mem_wready,
    output fb_pkg::fb_addr_t     mem_waddr,
    output fb_pkg::fb_pixel_t    mem_wdata,
    output fb_pkg::fb_buf_e      mem_wbuf,

    output logic                 swap_fb,
    input  wire                  fb_swapped,
    output fb_pkg::fb_addr_t     fb_addr
);
    import fb_pkg::*;

    logic        clear_start;
    logic        clear_color_en;
    logic        clear_depth_en;
    logic        clear_busy;
    logic        swap_start;
    logic        swap_busy;
    screen_pos_t x_res;
    screen_pos_t y_res;
    screen_pos_t sc_start_x;
    screen_pos_t sc_start_y;
    screen_pos_t sc_end_x;
    screen_pos_t sc_end_y;
    logic        sc_enable;
    fb_addr_t    color_base;
    fb_addr_t    depth_base;
    fb_pixel_t   clear_rgb565;
    fb_pixel_t   clear_depth;
    logic        beat_valid;
    logic        beat_ready;
    fb_addr_t    beat_addr;
    fb_pixel_t   beat_data;
    fb_buf_e     beat_buf;

    // Display scans out of the current color buffer
    assign fb_addr = color_base;

    fb_cmd_decode u_cmd_decode (
        .aclk(aclk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
        .clear_busy(clear_busy), .swap_busy(swap_busy),
        .clear_start(clear_start), .clear_color_en(clear_color_en),
        .clear_depth_en(clear_depth_en), .swap_start(swap_start),
        .x_res(x_res), .y_res(y_res),
        .sc_start_x(sc_start_x), .sc_start_y(sc_start_y),
        .sc_end_x(sc_end_x), .sc_end_y(sc_end_y), .sc_enable(sc_enable),
        .color_base(color_base), .depth_base(depth_base),
        .clear_rgb565(clear_rgb565), .clear_depth(clear_depth)
    );

    fb_clear_engine u_clear_engine (
        .aclk(aclk), .rst_n(rst_n),
        .clear_start(clear_start), .clear_color_en(clear_color_en),
        .clear_depth_en(clear_depth_en), .clear_busy(clear_busy),
        .x_res(x_res), .y_res(y_res),
        .sc_start_x(sc_start_x), .sc_start_y(sc_start_y),
        .sc_end_x(sc_end_x), .sc_end_y(sc_end_y), .sc_enable(sc_enable),
        .color_base(color_base), .depth_base(depth_base),
        .clear_rgb565(clear_rgb565), .clear_depth(clear_depth),
        .beat_valid(beat_valid), .beat_ready(beat_ready),
        .beat_addr(beat_addr), .beat_data(beat_data), .beat_buf(beat_buf)
    );

    fb_output_stage u_output_stage (
        .aclk(aclk), .rst_n(rst_n),
        .beat_valid(beat_valid), .beat_ready(beat_ready),
        .beat_addr(beat_addr), .beat_data(beat_data), .beat_buf(beat_buf),
        .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
        .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_wbuf(mem_wbuf),
        .swap_start(swap_start), .fb_swapped(fb_swapped),
        .swap_fb(swap_fb), .swap_busy(swap_busy)
    );

endmodule

`default_nettype wire

// File: tests/tb_rasterix_fb_assert.sv
// Framebuffer protocol assertions
`timescale 1ns/1ps
`default_nettype none

module fb_protocol_assert (
    input wire               aclk,
    input wire               rst_n,
    input wire               cmd_ready,
    input wire               mem_wvalid,
    input wire               mem_wready,
    input fb_pkg::fb_addr_t  mem_waddr,
    input fb_pkg::fb_pixel_t mem_wdata,
    input fb_pkg::fb_buf_e   mem_wbuf,
    input wire               swap_fb
);
    import fb_pkg::*;

    swap_single: assert property (@(posedge aclk) disable iff (!rst_n)
        swap_fb |=> !swap_fb)
        else $error("swap_fb high on two cycles in a row");

    // Stalled beat holds every field
    beat_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        (mem_wvalid && !mem_wready) |=>
            (mem_wvalid && $stable(mem_waddr) && $stable(mem_wdata) && $stable(mem_wbuf)))
        else $error("stalled write beat changed");

    // Writes only happen while a memset holds the command port
    ready_vs_write: assert property (@(posedge aclk) disable iff (!rst_n)
        mem_wvalid |-> !cmd_ready)
        else $error("cmd_ready high while a write beat is pending");

endmodule

bind rasterix_fb fb_protocol_assert u_protocol_assert (
    .aclk(aclk), .rst_n(rst_n), .cmd_ready(cmd_ready),
    .mem_wvalid(mem_wvalid), .mem_wready(mem_wready), .mem_waddr(mem_waddr),
    .mem_wdata(mem_wdata), .mem_wbuf(mem_wbuf), .swap_fb(swap_fb)
);

`default_nettype wire

// File: tests/tb_rasterix_fb.sv
// Framebuffer control testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rasterix_fb;
    import fb_pkg::*;

    typedef struct {
        cmd_word_t cmd;
        int        n_color;
        int        n_depth;
        fb_addr_t  color_first;
        fb_addr_t  depth_first;
        fb_pixel_t color_data;
        fb_pixel_t depth_data;
        int        x_res;
        int        win_w;
        bit        swap;
    } row_t;

    logic       aclk;
    logic       rst_n;
    logic       cmd_valid;
    cmd_word_t  cmd_data;
    logic       cmd_ready;
    logic       mem_wvalid;
    logic       mem_wready;
    fb_addr_t   mem_waddr;
    fb_pixel_t  mem_wdata;
    fb_buf_e    mem_wbuf;
    logic       swap_fb;
    logic       fb_swapped;
    fb_addr_t   fb_addr;

    row_t       rows[$];
    fb_addr_t   got_addr[$];
    fb_pixel_t  got_data[$];
    fb_buf_e    got_buf[$];
    int         cycle = 0;
    int         swap_count = 0;
    int         swap_cycle = 0;
    int         swapped_cycle = 0;
    int         errors = 0;
    int         test_errors = 0;
    logic [31:0] lfsr = 32'hbae4;

    rasterix_fb u_rasterix_fb (
        .aclk(aclk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
        .mem_wvalid(mem_wvalid), .mem_wready(mem_wready), .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata), .mem_wbuf(mem_wbuf),
        .swap_fb(swap_fb), .fb_swapped(fb_swapped), .fb_addr(fb_addr)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Random back-pressure, one LFSR bit per cycle
    initial
    begin
        mem_wready = 1'b0;
        forever
        begin
            @(posedge aclk);
            lfsr = lfsr_step(lfsr);
            mem_wready <= lfsr[0];
        end
    end

    always @(posedge aclk)
    begin
        cycle <= cycle + 1;
        if (rst_n && mem_wvalid && mem_wready)
        begin
            got_addr.push_back(mem_waddr);
            got_data.push_back(mem_wdata);
            got_buf.push_back(mem_wbuf);
        end
        if (rst_n && swap_fb)
        begin
            swap_count = swap_count + 1;
            swap_cycle = cycle;
        end
    end

    // Display side acknowledges a few cycles after each swap pulse
    initial
    begin
        fb_swapped = 1'b0;
        forever
        begin
            @(posedge aclk);
            if (swap_fb)
            begin
                repeat (3) @(posedge aclk);
                fb_swapped <= 1'b1;
                @(posedge aclk);
                fb_swapped <= 1'b0;
            end
        end
    end

    task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        errors = errors + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic check_addr(input string name, input fb_addr_t got, input fb_addr_t exp);
        if (got !== exp)
            report_err(name, 32'(got), 32'(exp));
    endtask

    task automatic check_pixel(input string name, input fb_pixel_t got, input fb_pixel_t exp);
        if (got !== exp)
            report_err(name, 32'(got), 32'(exp));
    endtask

    task automatic check_buf(input string name, input fb_buf_e got, input fb_buf_e exp);
        if (got !== exp)
            report_err(name, 32'(got), 32'(exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_err(name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_err(name, 32'(got), 32'(exp));
    endtask

    task automatic note_timeout(input string why);
        $display("%s", why);
        errors = errors + 1;
    endtask

    task automatic add_row(input cmd_word_t cmd, input int nc, input int nd, input fb_addr_t cf,
                           input fb_addr_t df, input fb_pixel_t cd, input fb_pixel_t dd,
                           input int xr, input int ww, input bit sw);
        row_t r;
        r = '{cmd, nc, nd, cf, df, cd, dd, xr, ww, sw};
        rows.push_back(r);
    endtask

    task automatic check_beats(input row_t r);
        int       nc;
        int       nd;
        int       k;
        fb_addr_t exp;
        nc = 0;
        nd = 0;
        foreach (got_buf[j])
        begin
            if (got_buf[j] == buf_color)
                nc = nc + 1;
            else
                nd = nd + 1;
        end
        check_count("color_beats", nc, r.n_color);
        check_count("depth_beats", nd, r.n_depth);
        if (got_buf.size() != r.n_color + r.n_depth)
            return;
        foreach (got_buf[j])
        begin
            // Color beats first in row-major order, then depth
            k   = (j < r.n_color) ? j : j - r.n_color;
            exp = (j < r.n_color) ? r.color_first : r.depth_first;
            exp = exp + fb_addr_t'((k / r.win_w) * r.x_res + (k % r.win_w));
            check_addr("mem_waddr", got_addr[j], exp);
            check_buf("mem_wbuf", got_buf[j], (j < r.n_color) ? buf_color : buf_depth);
            check_pixel("mem_wdata", got_data[j], (j < r.n_color) ? r.color_data : r.depth_data);
        end
    endtask

    initial
    begin
        int n;
        int acc_cycle;
        int ready_cycle;
        int tests_run;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        tests_run = 0;

        add_row(32'hA000_0003, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h1000_2008, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h5000_1000, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h70FF_8040, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'hA000_0001, 32, 0, 20'h01000, '0, 16'hFC08, '0, 8, 8, 0);
        add_row(32'h2000_0802, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h3000_1805, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h4000_0001, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h6008_0000, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'h8000_1234, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'hA000_0003, 6, 6, 20'h0100A, 20'h8000A, 16'hFC08, 16'h1234, 8, 3, 0);
        add_row(32'h9000_0001, 0, 0, '0, '0, '0, '0, 1, 1, 0);
        add_row(32'hA000_0003, 6, 0, 20'h0100A, '0, 16'hFC08, '0, 8, 3, 0);
        add_row(32'hB000_0000, 0, 0, '0, '0, '0, '0, 1, 1, 1);

        repeat (16) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        @(posedge aclk);
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("mem_wvalid", mem_wvalid, 1'b0);
        check_flag("swap_fb", swap_fb, 1'b0);

        foreach (rows[i])
        begin
            test_errors = 0;
            got_addr.delete();
            got_data.delete();
            got_buf.delete();
            swap_count = 0;
            swapped_cycle = -1;
            cmd_valid <= 1'b1;
            cmd_data  <= rows[i].cmd;
            n = 0;
            do
            begin
                @(posedge aclk);
                n = n + 1;
            end
            while (!cmd_ready && (n < 100));
            if (!cmd_ready)
            begin
                note_timeout("Timed out waiting for a command to be accepted");
                break;
            end
            acc_cycle = cycle;
            cmd_valid <= 1'b0;
            if (rows[i].swap)
            begin
                n = 0;
                do
                begin
                    @(posedge aclk);
                    n = n + 1;
                end
                while (!swap_fb && (n < 20));
                if (!swap_fb)
                begin
                    note_timeout("The swap_fb pulse never came after a swap command");
                    break;
                end
            end
            n = 0;
            do
            begin
                @(posedge aclk);
                n = n + 1;
                // First cycle the display side acknowledged
                if (fb_swapped && (swapped_cycle < 0))
                    swapped_cycle = cycle;
            end
            while (!cmd_ready && (n < 2000));
            if (!cmd_ready)
            begin
                note_timeout("Timed out waiting for cmd_ready to return");
                break;
            end
            ready_cycle = cycle;
            repeat (2) @(posedge aclk);
            check_beats(rows[i]);
            check_count("swap_pulses", swap_count, rows[i].swap ? 1 : 0);
            if (rows[i].swap)
            begin
                check_count("swap_cycle", swap_cycle, acc_cycle + 1);
                check_addr("fb_addr", fb_addr, 20'h01000);
                if ((swapped_cycle < 0) || (ready_cycle <= swapped_cycle))
                begin
                    $display("cmd_ready rose before fb_swapped was seen high");
                    errors = errors + 1;
                    test_errors = test_errors + 1;
                end
            end
            $display("test %0d cmd %h %s", i, rows[i].cmd, (test_errors == 0) ? "ok" : "failed");
            tests_run = tests_run + 1;
        end

        $display("tests %0d errors %0d", tests_run, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
verilog/fb_pkg.sv
verilog/fb_cmd_decode.sv
verilog/fb_clear_engine.sv
verilog/fb_output_stage.sv
verilog/rasterix_fb.sv
tests/tb_rasterix_fb_assert.sv
tests/tb_rasterix_fb.sv

// File: Makefile
TOP = tb_rasterix_fb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall verilog/fb_pkg.sv verilog/fb_cmd_decode.sv \
		verilog/fb_clear_engine.sv verilog/fb_output_stage.sv verilog/rasterix_fb.sv \
		--top-module rasterix_fb

clean:
	rm -rf obj_dir
